//--- all.f
axi_regs_pkg.sv
reg_access_if.sv
axi_lite_wr_channel.sv
axi_lite_rd_channel.sv
snap_reg_bank.sv
snap_ctrl_regs.sv
tb_snap_ctrl_regs.sv

//--- axi_lite_rd_channel.sv
/*
 * AXI4-Lite read side
 *  - address and data handshake FSM
 *  - read word registered on the address handshake
 *  - word held stable under R back-pressure
 */
module axi_lite_rd_channel (
   input  logic                clk,
   input  logic                rst_n,
   // Read address
   input  axi_regs_pkg::addr_t araddr,
   input  logic                arvalid,
   output logic                arready,
   // Read data
   output axi_regs_pkg::data_t rdata,
   output axi_regs_pkg::resp_t rresp,
   output logic                rvalid,
   input  logic                rready,
   // To register bank
   reg_access_if.reader        regs
);

   axi_regs_pkg::rd_state_e state;
   logic                    ar_hs;
   logic                    r_hs;

   assign arready = (state == axi_regs_pkg::RD_ADDR);
   assign rvalid  = (state == axi_regs_pkg::RD_DATA);
   assign rresp   = axi_regs_pkg::RESP_OKAY;

   assign ar_hs = arvalid & arready;
   assign r_hs  = rvalid & rready;

   // Bank lookup is combinational on the incoming address
   assign regs.rd_addr = araddr;

   // ----------------------------------------------------------
   // FSM
   // ----------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= axi_regs_pkg::RD_ADDR;
      end else begin
         case (state)
            axi_regs_pkg::RD_ADDR: if (ar_hs) state <= axi_regs_pkg::RD_DATA;
            axi_regs_pkg::RD_DATA: if (r_hs) state <= axi_regs_pkg::RD_ADDR;
            default: state <= axi_regs_pkg::RD_ADDR;
         endcase
      end
   end

   // Read data word
   // only loaded on address handshake, so it holds while rvalid waits
   always_ff @(posedge clk) begin
      if (ar_hs) begin
         rdata <= regs.rd_data;
      end
   end

endmodule

//--- axi_lite_wr_channel.sv
/*
 * AXI4-Lite write side
 *  - address, data and response handshake FSM
 *  - one write in flight at a time
 *  - register write strobe on the data beat
 */
module axi_lite_wr_channel (
   input  logic                clk,
   input  logic                rst_n,
   // Write address
   input  axi_regs_pkg::addr_t awaddr,
   input  logic                awvalid,
   output logic                awready,
   // Write data
   input  axi_regs_pkg::data_t wdata,
   input  axi_regs_pkg::strb_t wstrb,
   input  logic                wvalid,
   output logic                wready,
   // Write response
   output axi_regs_pkg::resp_t bresp,
   output logic                bvalid,
   input  logic                bready,
   // To register bank
   reg_access_if.writer        regs
);

   axi_regs_pkg::wr_state_e state;
   axi_regs_pkg::wr_state_e state_nxt;
   axi_regs_pkg::addr_t     addr_q;
   logic                    aw_hs;
   logic                    w_hs;
   logic                    b_hs;

   // Ready and valid come straight from the state
   assign awready = (state == axi_regs_pkg::WR_ADDR);
   assign wready  = (state == axi_regs_pkg::WR_DATA);
   assign bvalid  = (state == axi_regs_pkg::WR_RESP);
   assign bresp   = axi_regs_pkg::RESP_OKAY;

   assign aw_hs = awvalid & awready;
   assign w_hs  = wvalid & wready;
   assign b_hs  = bvalid & bready;

   // ----------------------------------------------------------
   // FSM
   // ----------------------------------------------------------
   always_comb begin
      state_nxt = state;
      case (state)
         axi_regs_pkg::WR_ADDR: begin
            if (aw_hs) state_nxt = axi_regs_pkg::WR_DATA;
         end
         axi_regs_pkg::WR_DATA: begin
            // Register updates on this same edge
            if (w_hs) state_nxt = axi_regs_pkg::WR_RESP;
         end
         axi_regs_pkg::WR_RESP: begin
            // Held here under B back-pressure, no new address taken
            if (b_hs) state_nxt = axi_regs_pkg::WR_ADDR;
         end
         default: state_nxt = axi_regs_pkg::WR_ADDR;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= axi_regs_pkg::WR_ADDR;
      end else begin
         state <= state_nxt;
      end
   end

   // Captured write address, payload only
   always_ff @(posedge clk) begin
      if (aw_hs) begin
         addr_q <= awaddr;
      end
   end

   // ----------------------------------------------------------
   // Register write port
   // ----------------------------------------------------------
   assign regs.wr_en   = w_hs;
   assign regs.wr_addr = addr_q;
   assign regs.wr_data = wdata;
   assign regs.wr_strb = wstrb;

endmodule

//--- axi_regs_pkg.sv
/*
 * Shared definitions for the AXI4-Lite action control block
 *  - bus widths and vector types
 *  - response code and unmapped read pattern
 *  - register offset map
 *  - write and read channel state encodings
 *  - bit positions inside control and status words
 */
package axi_regs_pkg;

   // ----------------------------------------------------------
   // Bus widths
   // ----------------------------------------------------------
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [STRB_W-1:0] strb_t;
   typedef logic [1:0]        resp_t;

   // Only OKAY is ever returned
   localparam resp_t RESP_OKAY = 2'b00;

   // Pattern for reads that hit no register
   localparam data_t UNMAPPED_DATA = 32'h5a5a_a5a5;

   // ----------------------------------------------------------
   // Register map, byte offsets
   // ----------------------------------------------------------
   typedef enum logic [ADDR_W-1:0] {
      OFF_SNAP_CONTROL   = 32'h00,
      OFF_ACTION_TYPE    = 32'h10,
      OFF_ACTION_VERSION = 32'h14,
      OFF_SNAP_CONTEXT   = 32'h20,
      OFF_USER_STATUS    = 32'h30,
      OFF_USER_CONTROL   = 32'h34,
      OFF_SOURCE_L       = 32'h38,
      OFF_SOURCE_H       = 32'h3C,
      OFF_TARGET_L       = 32'h40,
      OFF_TARGET_H       = 32'h44,
      OFF_MB_W           = 32'h50,
      OFF_MB_H           = 32'h54,
      OFF_SOFT_RESET     = 32'h58
   } reg_offset_e;

   // Channel FSM states
   typedef enum logic [1:0] {WR_ADDR, WR_DATA, WR_RESP} wr_state_e;
   typedef enum logic {RD_ADDR, RD_DATA} rd_state_e;

   // Action control word
   localparam int SNAP_START_BIT = 0;
   localparam int SNAP_IDLE_BIT  = 2;
   localparam int SNAP_READY_BIT = 3;

   // User control word
   localparam int USER_START_BIT = 0;

   // User status word, all sticky
   localparam int STAT_DONE_BIT   = 0;
   localparam int STAT_WR_ERR_BIT = 1;
   localparam int STAT_RD_ERR_BIT = 2;

endpackage

//--- reg_access_if.sv
/*
 * Register access path between the AXI channels and the register bank
 *  - write port, one strobed word per accepted data beat
 *  - read port, combinational lookup by address
 */
interface reg_access_if;

   // Write path, driven by the write channel
   logic                wr_en;
   axi_regs_pkg::addr_t wr_addr;
   axi_regs_pkg::data_t wr_data;
   axi_regs_pkg::strb_t wr_strb;

   // Read path, address out and word back in the same cycle
   axi_regs_pkg::addr_t rd_addr;
   axi_regs_pkg::data_t rd_data;

   modport writer (output wr_en, output wr_addr, output wr_data, output wr_strb);

   modport reader (output rd_addr, input rd_data);

   modport bank (
      input  wr_en, input wr_addr, input wr_data, input wr_strb,
      input  rd_addr,
      output rd_data
   );

endinterface

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert --top-module tb_snap_ctrl_regs \
   -f all.f -o tb_snap_ctrl_regs > build.log 2>&1 \
   && ./obj_dir/tb_snap_ctrl_regs > sim.log 2>&1 \
   || { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -qx "Regression passed" sim.log && exit 0 || exit 1

//--- snap_ctrl_patterns.txt
# op offset data strb expected, all hex; a line starting with = names a group
# O checks the local output of that offset; S waits data cycles, counts start_pulse
= reset_values
R 00 0 0 00000008
R 10 0 0 10141000
R 14 0 0 00000102
R 20 0 0 00000000
R 30 0 0 00000000
R 34 0 0 00000000
R 38 0 0 00000000
R 3c 0 0 00000000
R 40 0 0 00000000
R 44 0 0 00000000
R 50 0 0 00000000
R 54 0 0 00000000
R 58 0 0 00000000
R 0c 0 0 5a5aa5a5
= strobe_merge
W 20 11223344 f 0
W 50 aabbccdd 5 0
W 54 01020304 2 0
W 38 89abcdef f 0
W 3c 55667788 8 0
W 40 0badf00d c 0
W 44 cafef00d f 0
W 44 00001234 3 0
R 20 0 0 11223344
O 20 0 0 11223344
O 50 0 0 00bb00dd
R 54 0 0 00000300
O 38 0 0 89abcdef
O 3c 0 0 55000000
R 40 0 0 0bad0000
R 44 0 0 cafe1234
O 44 0 0 cafe1234
= user_start
W 34 00000101 f 0
S 0 4 0 00000001
R 34 0 0 00000100
= sticky_status
W 00 00000101 f 0
D 0 0 0 0
E 0 0 0 0
F 0 0 0 0
W 34 00000000 f 0
R 30 0 0 00000007
R 00 0 0 0000010d
= soft_reset
W 58 00000001 1 0
R 58 0 0 00000000
R 30 0 0 00000000
R 00 0 0 00000008
R 20 0 0 00000000
O 38 0 0 00000000
O 44 0 0 00000000
O 50 0 0 00000000
S 0 4 0 00000000

//--- snap_ctrl_regs.sv
/*
 * Top level of the AXI4-Lite action control block
 *  - plain AXI4-Lite slave and local ports
 *  - write channel, read channel and register bank
 *  - one shared register access interface
 */
module snap_ctrl_regs (
   input  logic                clk,
   input  logic                rst_n,
   // ----------------------------------------------------------
   // AXI4-Lite slave
   // ----------------------------------------------------------
   input  axi_regs_pkg::addr_t awaddr,
   input  logic                awvalid,
   output logic                awready,
   input  axi_regs_pkg::data_t wdata,
   input  axi_regs_pkg::strb_t wstrb,
   input  logic                wvalid,
   output logic                wready,
   output axi_regs_pkg::resp_t bresp,
   output logic                bvalid,
   input  logic                bready,
   input  axi_regs_pkg::addr_t araddr,
   input  logic                arvalid,
   output logic                arready,
   output axi_regs_pkg::data_t rdata,
   output axi_regs_pkg::resp_t rresp,
   output logic                rvalid,
   input  logic                rready,
   // ----------------------------------------------------------
   // Local control and status
   // ----------------------------------------------------------
   output logic                start_pulse,
   output logic [63:0]         source_address,
   output logic [63:0]         target_address,
   output axi_regs_pkg::data_t mb_w,
   output axi_regs_pkg::data_t mb_h,
   output axi_regs_pkg::data_t snap_context,
   input  logic                done_pulse,
   input  logic                wr_error,
   input  logic                rd_error,
   input  axi_regs_pkg::data_t action_type,
   input  axi_regs_pkg::data_t action_version
);

   // Shared by both channels and the bank
   reg_access_if regs_if ();

   // Write channel, one write in flight
   axi_lite_wr_channel wr_channel_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .awaddr  (awaddr),
      .awvalid (awvalid),
      .awready (awready),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .wvalid  (wvalid),
      .wready  (wready),
      .bresp   (bresp),
      .bvalid  (bvalid),
      .bready  (bready),
      .regs    (regs_if)
   );

   // Read channel, runs alongside the write channel
   axi_lite_rd_channel rd_channel_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .araddr  (araddr),
      .arvalid (arvalid),
      .arready (arready),
      .rdata   (rdata),
      .rresp   (rresp),
      .rvalid  (rvalid),
      .rready  (rready),
      .regs    (regs_if)
   );

   snap_reg_bank reg_bank_i (
      .clk            (clk),
      .rst_n          (rst_n),
      .regs           (regs_if),
      .done_pulse     (done_pulse),
      .wr_error       (wr_error),
      .rd_error       (rd_error),
      .action_type    (action_type),
      .action_version (action_version),
      .start_pulse    (start_pulse),
      .source_address (source_address),
      .target_address (target_address),
      .mb_w           (mb_w),
      .mb_h           (mb_h),
      .snap_context   (snap_context)
   );

endmodule

//--- snap_reg_bank.sv
/*
 * Register bank of the action control block
 *  - strobed writes into the control and address registers
 *  - self-clearing user start bit and soft reset
 *  - sticky done and error status, idle capture
 *  - combinational read decode
 */
module snap_reg_bank (
   input  logic                clk,
   input  logic                rst_n,
   reg_access_if.bank          regs,
   // Local status
   input  logic                done_pulse,
   input  logic                wr_error,
   input  logic                rd_error,
   input  axi_regs_pkg::data_t action_type,
   input  axi_regs_pkg::data_t action_version,
   // Local control
   output logic                start_pulse,
   output logic [63:0]         source_address,
   output logic [63:0]         target_address,
   output axi_regs_pkg::data_t mb_w,
   output axi_regs_pkg::data_t mb_h,
   output axi_regs_pkg::data_t snap_context
);

   // Stored registers
   axi_regs_pkg::data_t snap_control;
   axi_regs_pkg::data_t user_control;
   axi_regs_pkg::data_t soft_reset_reg;

   // Status and derived bits
   logic                snap_start_q;
   logic                snap_idle_q;
   logic                done_q;
   logic                wr_err_q;
   logic                rd_err_q;
   logic                soft_reset;
   axi_regs_pkg::data_t snap_control_rd;
   axi_regs_pkg::data_t user_status;

   // Keep old bytes where the strobe is low
   function automatic axi_regs_pkg::data_t merge(input axi_regs_pkg::data_t old_word,
                                                 input axi_regs_pkg::data_t new_word,
                                                 input axi_regs_pkg::strb_t strb);
      axi_regs_pkg::data_t mask;
      for (int i = 0; i < axi_regs_pkg::STRB_W; i++) begin
         mask[i*8 +: 8] = {8{strb[i]}};
      end
      return (new_word & mask) | (old_word & ~mask);
   endfunction

   assign soft_reset = soft_reset_reg[0];

   // ----------------------------------------------------------
   // Register writes
   // ----------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         snap_control   <= '0;
         snap_context   <= '0;
         user_control   <= '0;
         source_address <= '0;
         target_address <= '0;
         mb_w           <= '0;
         mb_h           <= '0;
         soft_reset_reg <= '0;
      end else if (soft_reset) begin
         // Clears itself along with everything else
         snap_control   <= '0;
         snap_context   <= '0;
         user_control   <= '0;
         source_address <= '0;
         target_address <= '0;
         mb_w           <= '0;
         mb_h           <= '0;
         soft_reset_reg <= '0;
      end else if (regs.wr_en) begin
         case (regs.wr_addr)
            axi_regs_pkg::OFF_SNAP_CONTROL:
               snap_control <= merge(snap_control, regs.wr_data, regs.wr_strb);
            axi_regs_pkg::OFF_SNAP_CONTEXT:
               snap_context <= merge(snap_context, regs.wr_data, regs.wr_strb);
            axi_regs_pkg::OFF_USER_CONTROL:
               user_control <= merge(user_control, regs.wr_data, regs.wr_strb);
            axi_regs_pkg::OFF_SOURCE_L:
               source_address[31:0] <=
                  merge(source_address[31:0], regs.wr_data, regs.wr_strb);
            axi_regs_pkg::OFF_SOURCE_H:
               source_address[63:32] <=
                  merge(source_address[63:32], regs.wr_data, regs.wr_strb);
            axi_regs_pkg::OFF_TARGET_L:
               target_address[31:0] <=
                  merge(target_address[31:0], regs.wr_data, regs.wr_strb);
            axi_regs_pkg::OFF_TARGET_H:
               target_address[63:32] <=
                  merge(target_address[63:32], regs.wr_data, regs.wr_strb);
            axi_regs_pkg::OFF_MB_W:
               mb_w <= merge(mb_w, regs.wr_data, regs.wr_strb);
            axi_regs_pkg::OFF_MB_H:
               mb_h <= merge(mb_h, regs.wr_data, regs.wr_strb);
            axi_regs_pkg::OFF_SOFT_RESET:
               soft_reset_reg <= merge(soft_reset_reg, regs.wr_data, regs.wr_strb);
            // Read-only and unmapped offsets drop the write
            default: ;
         endcase
      end else begin
         // Start bit lives for one cycle only
         user_control[axi_regs_pkg::USER_START_BIT] <= 1'b0;
      end
   end

   assign start_pulse = user_control[axi_regs_pkg::USER_START_BIT];

   // ----------------------------------------------------------
   // Status capture
   // ----------------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         snap_start_q <= 1'b0;
         snap_idle_q  <= 1'b0;
         done_q       <= 1'b0;
         wr_err_q     <= 1'b0;
         rd_err_q     <= 1'b0;
      end else if (soft_reset) begin
         snap_start_q <= 1'b0;
         snap_idle_q  <= 1'b0;
         done_q       <= 1'b0;
         wr_err_q     <= 1'b0;
         rd_err_q     <= 1'b0;
      end else begin
         // Delayed copy of the action start bit
         snap_start_q <= snap_control[axi_regs_pkg::SNAP_START_BIT];
         // Action finished, becomes idle
         if (done_pulse) begin
            snap_idle_q <= 1'b1;
            done_q      <= 1'b1;
         end
         if (wr_error) wr_err_q <= 1'b1;
         if (rd_error) rd_err_q <= 1'b1;
      end
   end

   // ----------------------------------------------------------
   // Read decode
   // ----------------------------------------------------------
   always_comb begin
      snap_control_rd = snap_control;
      snap_control_rd[axi_regs_pkg::SNAP_READY_BIT] = 1'b1;
      snap_control_rd[axi_regs_pkg::SNAP_IDLE_BIT]  = snap_idle_q;
      // Done bit unused here
      snap_control_rd[1] = 1'b0;
      snap_control_rd[axi_regs_pkg::SNAP_START_BIT] = snap_start_q;

      user_status = '0;
      user_status[axi_regs_pkg::STAT_DONE_BIT]   = done_q;
      user_status[axi_regs_pkg::STAT_WR_ERR_BIT] = wr_err_q;
      user_status[axi_regs_pkg::STAT_RD_ERR_BIT] = rd_err_q;
   end

   always_comb begin
      case (regs.rd_addr)
         axi_regs_pkg::OFF_SNAP_CONTROL:   regs.rd_data = snap_control_rd;
         axi_regs_pkg::OFF_ACTION_TYPE:    regs.rd_data = action_type;
         axi_regs_pkg::OFF_ACTION_VERSION: regs.rd_data = action_version;
         axi_regs_pkg::OFF_SNAP_CONTEXT:   regs.rd_data = snap_context;
         axi_regs_pkg::OFF_USER_STATUS:    regs.rd_data = user_status;
         axi_regs_pkg::OFF_USER_CONTROL:   regs.rd_data = user_control;
         axi_regs_pkg::OFF_SOURCE_L:       regs.rd_data = source_address[31:0];
         axi_regs_pkg::OFF_SOURCE_H:       regs.rd_data = source_address[63:32];
         axi_regs_pkg::OFF_TARGET_L:       regs.rd_data = target_address[31:0];
         axi_regs_pkg::OFF_TARGET_H:       regs.rd_data = target_address[63:32];
         axi_regs_pkg::OFF_MB_W:           regs.rd_data = mb_w;
         axi_regs_pkg::OFF_MB_H:           regs.rd_data = mb_h;
         axi_regs_pkg::OFF_SOFT_RESET:     regs.rd_data = soft_reset_reg;
         default:                          regs.rd_data = axi_regs_pkg::UNMAPPED_DATA;
      endcase
   end

endmodule

//--- tb_snap_ctrl_regs.sv
/*
 * Testbench for the AXI4-Lite action control block
 *  - clock, reset and fixed action type and version inputs
 *  - AXI4-Lite write and read tasks with random B and R back-pressure
 *  - pattern file reader, value checks and per-group report
 */
module tb_snap_ctrl_regs;

   localparam int TIMEOUT_CYCLES = 50;
   localparam axi_regs_pkg::data_t TYPE_VALUE    = 32'h1014_1000;
   localparam axi_regs_pkg::data_t VERSION_VALUE = 32'h0000_0102;

   logic                clk;
   logic                rst_n;
   axi_regs_pkg::addr_t awaddr;
   logic                awvalid;
   logic                awready;
   axi_regs_pkg::data_t wdata;
   axi_regs_pkg::strb_t wstrb;
   logic                wvalid;
   logic                wready;
   axi_regs_pkg::resp_t bresp;
   logic                bvalid;
   logic                bready;
   axi_regs_pkg::addr_t araddr;
   logic                arvalid;
   logic                arready;
   axi_regs_pkg::data_t rdata;
   axi_regs_pkg::resp_t rresp;
   logic                rvalid;
   logic                rready;
   logic                start_pulse;
   logic [63:0]         source_address;
   logic [63:0]         target_address;
   axi_regs_pkg::data_t mb_w;
   axi_regs_pkg::data_t mb_h;
   axi_regs_pkg::data_t snap_context;
   logic                done_pulse;
   logic                wr_error;
   logic                rd_error;
   axi_regs_pkg::data_t action_type;
   axi_regs_pkg::data_t action_version;

   // Run bookkeeping
   logic [31:0] lfsr;
   int          checks;
   int          errors;
   int          group_checks;
   int          group_errors;
   int          pulse_count;
   int          pulse_base;
   bit          timed_out;
   string       group_name;

   snap_ctrl_regs snap_ctrl_regs_i (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // start_pulse cycles counted on the rising edge
   always @(posedge clk) begin
      if (start_pulse) pulse_count <= pulse_count + 1;
   end

   // ----------------------------------------------------------
   // Random source and checks
   // ----------------------------------------------------------
   // One shift of the Galois LFSR
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0]) return (s >> 1) ^ 32'h8020_0003;
      return s >> 1;
   endfunction

   // One LFSR step per bit taken
   function automatic int draw_bits(input int nbits);
      int val;
      val = 0;
      for (int i = 0; i < nbits; i++) begin
         lfsr = lfsr_next(lfsr);
         val  = val * 2;
         if (lfsr[0]) val = val + 1;
      end
      return val;
   endfunction

   task automatic check_value(input string name, input axi_regs_pkg::data_t exp,
                              input axi_regs_pkg::data_t act);
      checks++;
      group_checks++;
      assert (act === exp) else begin
         $display("mismatch %s expected %h actual %h", name, exp, act);
         errors++;
         group_errors++;
      end
   endtask

   task automatic report_failure(input string what);
      checks++;
      group_checks++;
      errors++;
      group_errors++;
      $display("error: %s", what);
   endtask

   task automatic note_timeout(input string sig);
      report_failure($sformatf("no %s within %0d cycles", sig, TIMEOUT_CYCLES));
      timed_out = 1'b1;
   endtask

   // ----------------------------------------------------------
   // AXI4-Lite driver
   // ----------------------------------------------------------
   task automatic axi_write(input axi_regs_pkg::addr_t addr, input axi_regs_pkg::data_t data,
                            input axi_regs_pkg::strb_t strb);
      int waited;
      int stall;
      // Data offered together with the address and taken one beat later
      awaddr  = addr;
      awvalid = 1'b1;
      wdata   = data;
      wstrb   = strb;
      wvalid  = 1'b1;
      waited  = 0;
      while (!awready && waited < TIMEOUT_CYCLES) begin
         @(negedge clk);
         waited++;
      end
      if (!awready) begin
         note_timeout("awready");
         return;
      end
      @(negedge clk);
      awvalid = 1'b0;
      waited  = 0;
      while (!wready && waited < TIMEOUT_CYCLES) begin
         @(negedge clk);
         waited++;
      end
      if (!wready) begin
         note_timeout("wready");
         return;
      end
      @(negedge clk);
      wvalid = 1'b0;
      // B stalled for 0 to 3 cycles
      stall = draw_bits(2);
      repeat (stall) @(negedge clk);
      bready = 1'b1;
      waited = 0;
      while (!bvalid && waited < TIMEOUT_CYCLES) begin
         @(negedge clk);
         waited++;
      end
      if (!bvalid) begin
         note_timeout("bvalid");
         return;
      end
      check_value("bresp", {30'b0, axi_regs_pkg::RESP_OKAY}, {30'b0, bresp});
      @(negedge clk);
      bready = 1'b0;
   endtask

   task automatic axi_read(input axi_regs_pkg::addr_t addr, output axi_regs_pkg::data_t value);
      int                  waited;
      int                  stall;
      axi_regs_pkg::data_t first;
      value   = '0;
      araddr  = addr;
      arvalid = 1'b1;
      waited  = 0;
      while (!arready && waited < TIMEOUT_CYCLES) begin
         @(negedge clk);
         waited++;
      end
      if (!arready) begin
         note_timeout("arready");
         return;
      end
      @(negedge clk);
      arvalid = 1'b0;
      // Address moved off so a reloaded word would differ
      araddr  = ~addr;
      waited  = 0;
      while (!rvalid && waited < TIMEOUT_CYCLES) begin
         @(negedge clk);
         waited++;
      end
      if (!rvalid) begin
         note_timeout("rvalid");
         return;
      end
      first = rdata;
      // R stalled for 0 to 3 cycles while the word holds
      stall = draw_bits(2);
      repeat (stall) @(negedge clk);
      check_value("rdata held", first, rdata);
      check_value("rresp", {30'b0, axi_regs_pkg::RESP_OKAY}, {30'b0, rresp});
      rready = 1'b1;
      value  = rdata;
      @(negedge clk);
      rready = 1'b0;
   endtask

   // ----------------------------------------------------------
   // Local ports
   // ----------------------------------------------------------
   // One-cycle pulse on done_pulse, wr_error or rd_error
   task automatic pulse_status(input logic [7:0] op);
      done_pulse = (op == "D");
      wr_error   = (op == "E");
      rd_error   = (op == "F");
      @(negedge clk);
      done_pulse = 1'b0;
      wr_error   = 1'b0;
      rd_error   = 1'b0;
   endtask

   // Offsets whose register also shows on a local output
   function automatic bit drives_output(input axi_regs_pkg::addr_t offset);
      case (offset)
         axi_regs_pkg::OFF_SNAP_CONTEXT, axi_regs_pkg::OFF_SOURCE_L,
         axi_regs_pkg::OFF_SOURCE_H, axi_regs_pkg::OFF_TARGET_L,
         axi_regs_pkg::OFF_TARGET_H, axi_regs_pkg::OFF_MB_W,
         axi_regs_pkg::OFF_MB_H: return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   // Offset column picks the output that mirrors that register
   task automatic check_output(input axi_regs_pkg::addr_t offset, input axi_regs_pkg::data_t exp);
      case (offset)
         axi_regs_pkg::OFF_SNAP_CONTEXT: check_value("snap_context", exp, snap_context);
         axi_regs_pkg::OFF_SOURCE_L:
            check_value("source_address[31:0]", exp, source_address[31:0]);
         axi_regs_pkg::OFF_SOURCE_H:
            check_value("source_address[63:32]", exp, source_address[63:32]);
         axi_regs_pkg::OFF_TARGET_L:
            check_value("target_address[31:0]", exp, target_address[31:0]);
         axi_regs_pkg::OFF_TARGET_H:
            check_value("target_address[63:32]", exp, target_address[63:32]);
         axi_regs_pkg::OFF_MB_W: check_value("mb_w", exp, mb_w);
         axi_regs_pkg::OFF_MB_H: check_value("mb_h", exp, mb_h);
         default: report_failure($sformatf("no local output for offset %h", offset));
      endcase
   endtask

   task automatic finish_group();
      if (group_name != "") begin
         $display("group %s: %0d checks, %0d errors", group_name, group_checks, group_errors);
      end
      group_checks = 0;
      group_errors = 0;
   endtask

   // ----------------------------------------------------------
   // Pattern loop
   // ----------------------------------------------------------
   initial begin
      int                  fd;
      int                  n;
      string               line;
      logic [7:0]          op;
      axi_regs_pkg::addr_t offset;
      axi_regs_pkg::data_t data;
      axi_regs_pkg::strb_t strb;
      axi_regs_pkg::data_t expected;
      axi_regs_pkg::data_t rd_value;
      // All DUT inputs idle with reset held
      rst_n          = 1'b0;
      awaddr         = '0;
      awvalid        = 1'b0;
      wdata          = '0;
      wstrb          = '0;
      wvalid         = 1'b0;
      bready         = 1'b0;
      araddr         = '0;
      arvalid        = 1'b0;
      rready         = 1'b0;
      done_pulse     = 1'b0;
      wr_error       = 1'b0;
      rd_error       = 1'b0;
      action_type    = TYPE_VALUE;
      action_version = VERSION_VALUE;
      lfsr           = 32'h30c3;
      checks         = 0;
      errors         = 0;
      group_checks   = 0;
      group_errors   = 0;
      pulse_base     = 0;
      timed_out      = 1'b0;
      group_name     = "";
      repeat (4) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);

      fd = $fopen("snap_ctrl_patterns.txt", "r");
      if (fd == 0) begin
         report_failure("cannot open snap_ctrl_patterns.txt");
      end else begin
         while (!timed_out && $fgets(line, fd) > 0) begin
            if (line.len() < 2 || line[0] == "#") continue;
            // Group header with the name running to end of line
            if (line[0] == "=") begin
               finish_group();
               group_name = line.substr(2, line.len() - 2);
               continue;
            end
            n = $sscanf(line, "%c %h %h %h %h", op, offset, data, strb, expected);
            if (n != 5) begin
               report_failure($sformatf("unreadable pattern line %s", line));
               continue;
            end
            case (op)
               "W": axi_write(offset, data, strb);
               "R": begin
                  axi_read(offset, rd_value);
                  if (!timed_out) begin
                     check_value($sformatf("rdata[%h]", offset[7:0]), expected, rd_value);
                     // Mirrored registers show the same word on their output
                     if (drives_output(offset)) check_output(offset, expected);
                  end
               end
               "D", "E", "F": pulse_status(op);
               "S": begin
                  // Pulses counted since the previous S line
                  repeat (data) @(negedge clk);
                  check_value("start_pulse cycles", expected, pulse_count - pulse_base);
                  pulse_base = pulse_count;
               end
               "O": check_output(offset, expected);
               default: report_failure($sformatf("unknown operation %s", line));
            endcase
         end
         $fclose(fd);
         finish_group();
      end

      $display("checks %0d passed, %0d failed", checks - errors, errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule
